/* design/core_cfg_pkg.sv */
package core_cfg_pkg;

    // operand width of the integer datapath
    parameter int xlen = 32;

    parameter int preg_count = 64; // physical registers after rename
    parameter int preg_w = $clog2(preg_count);

    // defaults for the lane and port counts that the top level may override
    parameter int alu_lanes = 4; // lanes 0 and 1 are shared with csr and mult
    parameter int wb_ports = 3;

    // operands per memory port, fixed by the request structs
    parameter int load_reads = 1;
    parameter int store_reads = 2;

endpackage

/* design/regread_pkg.sv */
package regread_pkg;

    import core_cfg_pkg::*;

    // one issue slot asking for two source operands
    typedef struct packed {
        logic en; // doubles as valid on the shared lanes
        logic [preg_w-1:0] src0;
        logic [preg_w-1:0] src1;
    } read_req_t;

    typedef struct packed {
        logic en;
        logic [preg_w-1:0] src; // load only needs the base address register
    } load_req_t;

    typedef struct packed {
        logic data_valid;
        logic [xlen-1:0] data0;
        logic [xlen-1:0] data1;
    } read_rsp_t;

    typedef struct packed {
        logic data_valid;
        logic [xlen-1:0] data;
    } load_rsp_t;

    // one writeback bus entry which also feeds operand forwarding
    typedef struct packed {
        logic valid;
        logic we; // low for results that do not target a register
        logic [preg_w-1:0] rd;
        logic [xlen-1:0] res;
    } wb_entry_t;

endpackage

/* design/issue_read_arbiter.sv */
`timescale 1ns/1ps

module issue_read_arbiter #(
    parameter int alu_lanes = core_cfg_pkg::alu_lanes,
    localparam int rd_ports = 2 * alu_lanes + core_cfg_pkg::load_reads
        + core_cfg_pkg::store_reads
) (
    input  logic clk,
    input  logic reset,
    input  regread_pkg::read_req_t [alu_lanes-1:0] alu_req,
    input  regread_pkg::read_req_t csr_req,
    input  regread_pkg::read_req_t mult_req,
    input  regread_pkg::read_req_t store_req,
    input  regread_pkg::load_req_t load_req,
    output logic [alu_lanes-1:0] alu_ready,
    output regread_pkg::read_rsp_t [alu_lanes-1:0] alu_rsp,
    output regread_pkg::read_rsp_t csr_rsp,
    output regread_pkg::read_rsp_t mult_rsp,
    output regread_pkg::read_rsp_t store_rsp,
    output regread_pkg::load_rsp_t load_rsp,
    output logic [rd_ports-1:0] rd_en,
    output logic [rd_ports-1:0][core_cfg_pkg::preg_w-1:0] rd_addr,
    input  logic [rd_ports-1:0][core_cfg_pkg::xlen-1:0] rd_data
);
    import core_cfg_pkg::*;

    // read port order is all src0, then all src1, then load, then store
    localparam int load_base = 2 * alu_lanes;
    localparam int store_base = load_base + load_reads;

    logic [alu_lanes-1:0] lane_en_d;
    logic [alu_lanes-1:0] lane_en_q;
    logic [rd_ports-1:0][preg_w-1:0] rd_addr_d;
    logic csr_win_q; // csr owned lane 0 in the response cycle
    logic mult_win_q;
    logic load_en_q;
    logic store_en_q;

    always_comb begin
        for (int i = 0; i < alu_lanes; i++) begin
            alu_ready[i] = 1'b1;
            lane_en_d[i] = alu_req[i].en;
            rd_addr_d[i] = alu_req[i].src0;
            rd_addr_d[alu_lanes + i] = alu_req[i].src1;
        end
        if (csr_req.en) begin
            alu_ready[0] = 1'b0; // the alu request on lane 0 waits
            lane_en_d[0] = 1'b1;
            rd_addr_d[0] = csr_req.src0;
            rd_addr_d[alu_lanes] = csr_req.src1;
        end
        if (mult_req.en) begin
            alu_ready[1] = 1'b0;
            lane_en_d[1] = 1'b1;
            rd_addr_d[1] = mult_req.src0;
            rd_addr_d[alu_lanes + 1] = mult_req.src1;
        end
        rd_addr_d[load_base] = load_req.src;
        rd_addr_d[store_base] = store_req.src0;
        rd_addr_d[store_base + 1] = store_req.src1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_en_q <= '0;
            csr_win_q <= 1'b0;
            mult_win_q <= 1'b0;
            load_en_q <= 1'b0;
            store_en_q <= 1'b0;
        end else begin
            lane_en_q <= lane_en_d;
            csr_win_q <= csr_req.en;
            mult_win_q <= mult_req.en;
            load_en_q <= load_req.en;
            store_en_q <= store_req.en;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= rd_addr_d;
    end

    always_comb begin
        for (int i = 0; i < alu_lanes; i++) begin
            rd_en[i] = lane_en_q[i];
            rd_en[alu_lanes + i] = lane_en_q[i]; // both operands of a lane read together
        end
        rd_en[load_base] = load_en_q;
        rd_en[store_base] = store_en_q;
        rd_en[store_base + 1] = store_en_q;
    end

    // the shared lanes return the same data and only the valid follows the winner
    always_comb begin
        for (int i = 0; i < alu_lanes; i++) begin
            alu_rsp[i].data_valid = lane_en_q[i];
            alu_rsp[i].data0 = rd_data[i];
            alu_rsp[i].data1 = rd_data[alu_lanes + i];
        end
        alu_rsp[0].data_valid = lane_en_q[0] & ~csr_win_q;
        alu_rsp[1].data_valid = lane_en_q[1] & ~mult_win_q;

        csr_rsp.data_valid = csr_win_q;
        csr_rsp.data0 = rd_data[0];
        csr_rsp.data1 = rd_data[alu_lanes];
        mult_rsp.data_valid = mult_win_q;
        mult_rsp.data0 = rd_data[1];
        mult_rsp.data1 = rd_data[alu_lanes + 1];

        load_rsp.data_valid = load_en_q;
        load_rsp.data = rd_data[load_base];
        store_rsp.data_valid = store_en_q;
        store_rsp.data0 = rd_data[store_base];
        store_rsp.data1 = rd_data[store_base + 1];
    end

endmodule

/* design/phys_regfile.sv */
`timescale 1ns/1ps

module phys_regfile #(
    parameter int alu_lanes = core_cfg_pkg::alu_lanes,
    parameter int wb_ports = core_cfg_pkg::wb_ports,
    localparam int rd_ports = 2 * alu_lanes + core_cfg_pkg::load_reads
        + core_cfg_pkg::store_reads
) (
    input  logic clk,
    input  logic [rd_ports-1:0][core_cfg_pkg::preg_w-1:0] rd_addr,
    output logic [rd_ports-1:0][core_cfg_pkg::xlen-1:0] rd_data,
    input  regread_pkg::wb_entry_t [wb_ports-1:0] wb_bus
);
    import core_cfg_pkg::*;

    logic [xlen-1:0] regs [preg_count];

    // ports never collide on one register, so the loop order does not matter
    always_ff @(posedge clk) begin
        for (int w = 0; w < wb_ports; w++) begin
            if (wb_bus[w].valid && wb_bus[w].we && wb_bus[w].rd != '0) begin
                regs[wb_bus[w].rd] <= wb_bus[w].res;
            end
        end
    end

    // entry 0 is never written and would read as x, hence the explicit zero
    always_comb begin
        for (int r = 0; r < rd_ports; r++) begin
            if (rd_addr[r] == '0) begin
                rd_data[r] = '0;
            end else begin
                rd_data[r] = regs[rd_addr[r]];
            end
        end
    end

endmodule

/* design/wb_bypass.sv */
`timescale 1ns/1ps

module wb_bypass #(
    parameter int alu_lanes = core_cfg_pkg::alu_lanes,
    parameter int wb_ports = core_cfg_pkg::wb_ports,
    localparam int rd_ports = 2 * alu_lanes + core_cfg_pkg::load_reads
        + core_cfg_pkg::store_reads
) (
    input  logic [rd_ports-1:0] rd_en,
    input  logic [rd_ports-1:0][core_cfg_pkg::preg_w-1:0] rd_addr,
    input  logic [rd_ports-1:0][core_cfg_pkg::xlen-1:0] raw_data,
    input  regread_pkg::wb_entry_t [wb_ports-1:0] wb_bus,
    output logic [rd_ports-1:0][core_cfg_pkg::xlen-1:0] fwd_data
);

    // the array only sees a write after the edge, so a result landing in the
    // response cycle has to be taken straight from the bus
    always_comb begin
        for (int r = 0; r < rd_ports; r++) begin
            fwd_data[r] = raw_data[r];
            if (rd_en[r] && rd_addr[r] != '0) begin
                for (int w = 0; w < wb_ports; w++) begin
                    if (wb_bus[w].valid && wb_bus[w].we && wb_bus[w].rd == rd_addr[r]) begin
                        fwd_data[r] = wb_bus[w].res; // at most one port can match
                    end
                end
            end
        end
    end

endmodule

/* design/regread_top.sv */
`timescale 1ns/1ps

module regread_top #(
    parameter int alu_lanes = core_cfg_pkg::alu_lanes,
    parameter int wb_ports = core_cfg_pkg::wb_ports,
    localparam int rd_ports = 2 * alu_lanes + core_cfg_pkg::load_reads
        + core_cfg_pkg::store_reads
) (
    input  logic clk,
    input  logic reset,
    input  regread_pkg::read_req_t [alu_lanes-1:0] alu_req,
    output logic [alu_lanes-1:0] alu_ready,
    input  regread_pkg::read_req_t csr_req,
    input  regread_pkg::read_req_t mult_req,
    input  regread_pkg::load_req_t load_req,
    input  regread_pkg::read_req_t store_req,
    input  regread_pkg::wb_entry_t [wb_ports-1:0] wb_bus,
    output regread_pkg::read_rsp_t [alu_lanes-1:0] alu_rsp,
    output regread_pkg::read_rsp_t csr_rsp,
    output regread_pkg::read_rsp_t mult_rsp,
    output regread_pkg::read_rsp_t store_rsp,
    output regread_pkg::load_rsp_t load_rsp
);
    import core_cfg_pkg::*;

    logic [rd_ports-1:0] rd_en;
    logic [rd_ports-1:0][preg_w-1:0] rd_addr;
    logic [rd_ports-1:0][xlen-1:0] raw_data; // array output before forwarding
    logic [rd_ports-1:0][xlen-1:0] fwd_data;

    issue_read_arbiter #(
        .alu_lanes(alu_lanes)
    ) arbiter (
        .clk(clk),
        .reset(reset),
        .alu_req(alu_req),
        .csr_req(csr_req),
        .mult_req(mult_req),
        .store_req(store_req),
        .load_req(load_req),
        .alu_ready(alu_ready),
        .alu_rsp(alu_rsp),
        .csr_rsp(csr_rsp),
        .mult_rsp(mult_rsp),
        .store_rsp(store_rsp),
        .load_rsp(load_rsp),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .rd_data(fwd_data)
    );

    phys_regfile #(
        .alu_lanes(alu_lanes),
        .wb_ports(wb_ports)
    ) regfile (
        .clk(clk),
        .rd_addr(rd_addr),
        .rd_data(raw_data),
        .wb_bus(wb_bus)
    );

    wb_bypass #(
        .alu_lanes(alu_lanes),
        .wb_ports(wb_ports)
    ) bypass (
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .raw_data(raw_data),
        .wb_bus(wb_bus),
        .fwd_data(fwd_data)
    );

endmodule

/* bench/regread_asserts.sv */
`timescale 1ns/1ps

module regread_asserts #(
    parameter int alu_lanes = core_cfg_pkg::alu_lanes
) (
    input logic clk,
    input logic reset,
    input regread_pkg::read_req_t [alu_lanes-1:0] alu_req,
    input regread_pkg::read_req_t csr_req,
    input regread_pkg::read_req_t mult_req,
    input regread_pkg::read_req_t store_req,
    input regread_pkg::load_req_t load_req,
    input logic [alu_lanes-1:0] alu_ready,
    input regread_pkg::read_rsp_t [alu_lanes-1:0] alu_rsp,
    input regread_pkg::read_rsp_t csr_rsp,
    input regread_pkg::read_rsp_t mult_rsp,
    input regread_pkg::read_rsp_t store_rsp,
    input regread_pkg::load_rsp_t load_rsp
);
    logic [alu_lanes-1:0] lane_valid;

    always_comb begin
        for (int i = 0; i < alu_lanes; i++) begin
            lane_valid[i] = alu_rsp[i].data_valid;
        end
    end

    csr_owns_lane0: assert property (@(posedge clk) disable iff (reset)
        alu_ready[0] == !csr_req.en) else $error("alu_ready[0] does not follow csr_req.en");
    mult_owns_lane1: assert property (@(posedge clk) disable iff (reset)
        alu_ready[1] == !mult_req.en) else $error("alu_ready[1] does not follow mult_req.en");

    for (genvar i = 0; i < alu_lanes; i++) begin : lane_rules
        lane_rsp: assert property (@(posedge clk) disable iff (reset)
            alu_req[i].en && alu_ready[i] |=> alu_rsp[i].data_valid)
            else $error("accepted ALU request got no response");
    end

    csr_rsp_next: assert property (@(posedge clk) disable iff (reset)
        csr_req.en |=> csr_rsp.data_valid) else $error("CSR request got no response");
    mult_rsp_next: assert property (@(posedge clk) disable iff (reset)
        mult_req.en |=> mult_rsp.data_valid) else $error("multiplier request got no response");
    load_rsp_next: assert property (@(posedge clk) disable iff (reset)
        load_req.en |=> load_rsp.data_valid) else $error("load request got no response");
    store_rsp_next: assert property (@(posedge clk) disable iff (reset)
        store_req.en |=> store_rsp.data_valid) else $error("store request got no response");

    // nothing may be valid straight out of reset
    quiet_after_reset: assert property (@(posedge clk) $past(reset) |-> !(|lane_valid
        || csr_rsp.data_valid || mult_rsp.data_valid || load_rsp.data_valid
        || store_rsp.data_valid)) else $error("response valid right after reset");

endmodule

bind issue_read_arbiter regread_asserts #(.alu_lanes(alu_lanes)) rules (
    .clk(clk), .reset(reset), .alu_req(alu_req), .csr_req(csr_req), .mult_req(mult_req),
    .store_req(store_req), .load_req(load_req), .alu_ready(alu_ready), .alu_rsp(alu_rsp),
    .csr_rsp(csr_rsp), .mult_rsp(mult_rsp), .store_rsp(store_rsp), .load_rsp(load_rsp)
);

/* bench/regread_tb.sv */
`timescale 1ns/1ps

module regread_tb;
    import core_cfg_pkg::*;
    import regread_pkg::*;

    logic clk;
    logic reset;
    read_req_t [alu_lanes-1:0] alu_req;
    logic [alu_lanes-1:0] alu_ready;
    read_req_t csr_req;
    read_req_t mult_req;
    read_req_t store_req;
    load_req_t load_req;
    wb_entry_t [wb_ports-1:0] wb_bus;
    read_rsp_t [alu_lanes-1:0] alu_rsp;
    read_rsp_t csr_rsp;
    read_rsp_t mult_rsp;
    read_rsp_t store_rsp;
    load_rsp_t load_rsp;

    // staged inputs, applied on the next falling edge
    logic s_reset;
    read_req_t [alu_lanes-1:0] s_alu;
    read_req_t s_csr;
    read_req_t s_mult;
    read_req_t s_store;
    load_req_t s_load;
    wb_entry_t [wb_ports-1:0] s_wb;

    logic [xlen-1:0] shadow [preg_count];
    read_req_t [alu_lanes-1:0] prev_alu; // what the coming edge accepts
    read_req_t prev_csr;
    read_req_t prev_mult;
    read_req_t prev_store;
    load_req_t prev_load;
    int checks;
    int errors;
    int test_start;
    int unsigned lcg_state;

    regread_top #(.alu_lanes(alu_lanes), .wb_ports(wb_ports)) UUT (
        .clk(clk), .reset(reset), .alu_req(alu_req), .alu_ready(alu_ready),
        .csr_req(csr_req), .mult_req(mult_req), .load_req(load_req), .store_req(store_req),
        .wb_bus(wb_bus), .alu_rsp(alu_rsp), .csr_rsp(csr_rsp), .mult_rsp(mult_rsp),
        .store_rsp(store_rsp), .load_rsp(load_rsp)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [preg_w-1:0] rand_reg();
        logic [31:0] r;
        r = lcg_next();
        return r[21:16];
    endfunction

    // array value, unless a result for the register sits on the bus right now
    function automatic logic [xlen-1:0] predict(logic [preg_w-1:0] addr);
        logic [xlen-1:0] value;
        value = shadow[addr];
        if (addr == '0) begin
            return '0;
        end
        for (int w = 0; w < wb_ports; w++) begin
            if (wb_bus[w].valid && wb_bus[w].we && wb_bus[w].rd == addr) begin
                value = wb_bus[w].res;
            end
        end
        return value;
    endfunction

    task automatic check_value(string name, logic [xlen-1:0] expected, logic [xlen-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic check_responses();
        logic win;
        for (int i = 0; i < alu_lanes; i++) begin
            win = (i == 0 && csr_req.en) || (i == 1 && mult_req.en);
            check_value($sformatf("alu_ready[%0d]", i), {31'b0, !win}, {31'b0, alu_ready[i]});
            check_value($sformatf("alu_rsp[%0d].data_valid", i), {31'b0, prev_alu[i].en},
                {31'b0, alu_rsp[i].data_valid});
            if (prev_alu[i].en) begin
                check_value($sformatf("alu_rsp[%0d].data0", i), predict(prev_alu[i].src0),
                    alu_rsp[i].data0);
                check_value($sformatf("alu_rsp[%0d].data1", i), predict(prev_alu[i].src1),
                    alu_rsp[i].data1);
            end
        end
        check_value("csr_rsp.data_valid", {31'b0, prev_csr.en}, {31'b0, csr_rsp.data_valid});
        check_value("mult_rsp.data_valid", {31'b0, prev_mult.en}, {31'b0, mult_rsp.data_valid});
        check_value("load_rsp.data_valid", {31'b0, prev_load.en}, {31'b0, load_rsp.data_valid});
        check_value("store_rsp.data_valid", {31'b0, prev_store.en},
            {31'b0, store_rsp.data_valid});
        if (prev_csr.en) begin
            check_value("csr_rsp.data0", predict(prev_csr.src0), csr_rsp.data0);
            check_value("csr_rsp.data1", predict(prev_csr.src1), csr_rsp.data1);
        end
        if (prev_mult.en) begin
            check_value("mult_rsp.data0", predict(prev_mult.src0), mult_rsp.data0);
            check_value("mult_rsp.data1", predict(prev_mult.src1), mult_rsp.data1);
        end
        if (prev_load.en) begin
            check_value("load_rsp.data", predict(prev_load.src), load_rsp.data);
        end
        if (prev_store.en) begin
            check_value("store_rsp.data0", predict(prev_store.src0), store_rsp.data0);
            check_value("store_rsp.data1", predict(prev_store.src1), store_rsp.data1);
        end
    endtask

    // drive on the falling edge, check once settled, then record what the next edge takes
    task automatic tick();
        @(negedge clk);
        reset = s_reset;
        alu_req = s_alu;
        csr_req = s_csr;
        mult_req = s_mult;
        load_req = s_load;
        store_req = s_store;
        wb_bus = s_wb;
        #10;
        check_responses();
        for (int w = 0; w < wb_ports; w++) begin
            if (wb_bus[w].valid && wb_bus[w].we && wb_bus[w].rd != '0) begin
                shadow[wb_bus[w].rd] = wb_bus[w].res;
            end
        end
        prev_alu = alu_req;
        prev_csr = csr_req;
        prev_mult = mult_req;
        prev_load = load_req;
        prev_store = store_req;
        prev_alu[0].en = alu_req[0].en && !csr_req.en; // stalled while the csr holds lane 0
        prev_alu[1].en = alu_req[1].en && !mult_req.en;
        if (reset) begin
            prev_alu = '0;
            prev_csr = '0;
            prev_mult = '0;
            prev_load = '0;
            prev_store = '0;
        end
    endtask

    task automatic clear_stage();
        s_alu = '0;
        s_csr = '0;
        s_mult = '0;
        s_load = '0;
        s_store = '0;
        s_wb = '0;
    endtask

    task automatic hold_until_served(int lane);
        int n;
        n = 0;
        do begin
            tick();
            if (prev_alu[lane].en) begin
                s_alu[lane].en = 1'b0; // accepted, so the requester lets go
            end
            n++;
        end while (!alu_rsp[lane].data_valid && n < 10);
        if (!alu_rsp[lane].data_valid) begin
            errors++;
            $display("ALU lane %0d got no response within 10 cycles", lane);
        end
    endtask

    task automatic random_stage();
        for (int i = 0; i < alu_lanes; i++) begin
            s_alu[i] = {lcg_next() > 32'h8000_0000, rand_reg(), rand_reg()};
        end
        s_csr = {lcg_next() > 32'hc000_0000, rand_reg(), rand_reg()};
        s_mult = {lcg_next() > 32'hc000_0000, rand_reg(), rand_reg()};
        s_load = {lcg_next() > 32'h8000_0000, rand_reg()};
        s_store = {lcg_next() > 32'h8000_0000, rand_reg(), rand_reg()};
        for (int w = 0; w < wb_ports; w++) begin
            s_wb[w] = {lcg_next() > 32'h6000_0000, lcg_next() > 32'h3000_0000, rand_reg(),
                lcg_next()};
            for (int v = 0; v < w; v++) begin
                if (s_wb[v].valid && s_wb[v].rd == s_wb[w].rd) begin
                    s_wb[w].valid = 1'b0; // two ports on one register is illegal
                end
            end
        end
    endtask

    task automatic report(string name);
        $display("%s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        clk = 1'b0;
        lcg_state = 71108;
        checks = 0;
        errors = 0;
        test_start = 0;
        reset = 1'b1;
        s_reset = 1'b1;
        clear_stage();
        alu_req = '0;
        csr_req = '0;
        mult_req = '0;
        load_req = '0;
        store_req = '0;
        wb_bus = '0;
        prev_alu = '0;
        prev_csr = '0;
        prev_mult = '0;
        prev_load = '0;
        prev_store = '0;
        repeat (2) tick();
        s_reset = 1'b0;

        for (int r = 1; r < preg_count; r += wb_ports) begin
            for (int w = 0; w < wb_ports; w++) begin
                s_wb[w] = {r + w < preg_count, 1'b1, preg_w'(r + w), lcg_next()};
            end
            tick();
        end
        s_wb = '0;
        for (int k = 0; k < 8; k++) begin
            for (int i = 0; i < alu_lanes; i++) begin
                s_alu[i] = {1'b1, rand_reg(), rand_reg()};
            end
            s_load = {1'b1, rand_reg()};
            s_store = {1'b1, rand_reg(), rand_reg()};
            tick();
        end
        clear_stage();
        tick();
        report("write then read on all ports");

        s_csr = {1'b1, 6'd5, 6'd6};
        s_alu[0] = {1'b1, 6'd7, 6'd8};
        repeat (2) tick();
        s_csr = '0;
        hold_until_served(0);
        report("csr takes lane 0");

        s_mult = {1'b1, 6'd9, 6'd10};
        s_alu[1] = {1'b1, 6'd11, 6'd12};
        repeat (2) tick();
        s_mult = '0;
        hold_until_served(1);
        report("multiplier takes lane 1");

        for (int w = 0; w < wb_ports; w++) begin
            s_alu[2] = {1'b1, preg_w'(20 + w), preg_w'(20 + w)};
            tick();
            s_alu[2] = '0;
            s_wb[w] = {1'b1, 1'b1, preg_w'(20 + w), lcg_next()};
            tick();
            s_wb = '0;
        end
        tick();
        report("writeback forwarding");

        s_wb[0] = {1'b1, 1'b1, 6'd0, 32'hdead_beef};
        tick();
        s_wb = '0;
        s_alu[3] = {1'b1, 6'd0, 6'd0};
        s_load = {1'b1, 6'd0};
        tick();
        clear_stage();
        s_wb[1] = {1'b1, 1'b1, 6'd0, 32'h1234_5678};
        tick();
        clear_stage();
        tick();
        report("register 0 reads zero");

        s_reset = 1'b1;
        repeat (3) tick();
        s_reset = 1'b0;
        repeat (5) tick();
        for (int k = 0; k < 200; k++) begin
            random_stage();
            tick();
        end
        clear_stage();
        tick();
        report("reset and random traffic");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
design/core_cfg_pkg.sv
design/regread_pkg.sv
design/issue_read_arbiter.sv
design/phys_regfile.sv
design/wb_bypass.sv
design/regread_top.sv
bench/regread_asserts.sv
bench/regread_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module regread_tb -f filelist.f -o regread_sim \
    > build.log 2>&1 \
    && ./obj_dir/regread_sim > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
